// ==== flist.f ====
verilog/udp_tx_pkg.sv
verilog/udp_tx_ifs.sv
verilog/payload_fifo.sv
verilog/eth_crc32.sv
verilog/udp_frame_tx.sv
verilog/udp_tx_top.sv
tb/udp_tx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the UDP transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module udp_tx_tb -f flist.f \
    -o sim_udp_tx > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/sim_udp_tx > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" sim.log; then
    exit 0
fi
exit 1

// ==== tb/udp_tx_tb.sv ====
`timescale 1ns/1ps

module udp_tx_tb;
    import udp_tx_pkg::*;

    localparam int CYCLE_LIMIT = 30000; // far above the ~1000 cycles of all tests

    logic        clk = 1'b0;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    logic [15:0] req_len;
    logic [31:0] req_des_ip;
    logic [47:0] req_des_mac;
    logic [7:0]  pay_data;
    logic        pay_valid;
    logic        pay_ready;
    logic        gmii_tx_en;
    logic [7:0]  gmii_txd;
    logic        tx_done;

    logic [7:0]  pay_q[$];  // payload of the current frame
    logic [7:0]  rx_q[$];   // bytes seen on gmii
    logic [7:0]  exp_q[$];  // model frame
    int          done_cnt = 0;
    int          cycles = 0;
    logic        prev_en = 1'b0; // tx_en one cycle back
    logic [15:0] next_ident = 16'd1;

    udp_tx_top udp_tx_top_inst (.*);

    always #50 clk = ~clk;

    // monitor and run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (gmii_tx_en) begin
            rx_q.push_back(gmii_txd);
        end
        if (tx_done) begin
            done_cnt++;
            compare_values({prev_en, gmii_tx_en}, 2'b10, "tx_done right after last fcs byte");
        end
        prev_en <= gmii_tx_en;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_values(input logic [63:0] got, input logic [63:0] exp,
                                  input string msg);
        if (got !== exp) begin
            $display("FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    //************************************************************
    // reference frame model
    //************************************************************
    function automatic logic [31:0] crc_step(input logic [31:0] c_in, input logic [7:0] b);
        logic [31:0] c;
        c = c_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ b[i])
                c = (c >> 1) ^ 32'hedb88320;
            else
                c = c >> 1;
        end
        return c;
    endfunction

    task automatic build_frame(input int len, input logic [31:0] ip, input logic [47:0] mac);
        logic [159:0] ip_h;
        logic [63:0]  udp_h;
        logic [47:0]  d_mac;
        logic [31:0]  sum;
        logic [31:0]  c;
        d_mac = (mac != '0) ? mac : DEFAULT_DES_MAC;
        ip_h  = {8'h45, 8'h00, 16'(len + 28), next_ident, 16'h4000, 8'h40, 8'd17, 16'h0,
                 BOARD_IP, (ip != '0) ? ip : DEFAULT_DES_IP};
        udp_h = {UDP_PORT, UDP_PORT, 16'(len + 8), 16'h0};
        sum   = '0;
        for (int k = 0; k < 10; k++) begin
            sum = sum + 32'(ip_h[16*k +: 16]);
        end
        while (sum[31:16] != '0) begin
            sum = 32'(sum[31:16]) + 32'(sum[15:0]); // end-around carry
        end
        ip_h[79:64] = ~sum[15:0];
        exp_q.delete();
        repeat (7) exp_q.push_back(8'h55);
        exp_q.push_back(8'hd5);
        for (int i = 5; i >= 0; i--) exp_q.push_back(d_mac[8*i +: 8]);
        for (int i = 5; i >= 0; i--) exp_q.push_back(BOARD_MAC[8*i +: 8]);
        exp_q.push_back(8'h08);
        exp_q.push_back(8'h00);
        for (int i = 19; i >= 0; i--) exp_q.push_back(ip_h[8*i +: 8]);
        for (int i = 7; i >= 0; i--) exp_q.push_back(udp_h[8*i +: 8]);
        for (int i = 0; i < len; i++) exp_q.push_back(pay_q[i]);
        for (int i = len; i < 18; i++) exp_q.push_back(8'h00); // pad
        c = 32'hffff_ffff;
        for (int i = 8; i < exp_q.size(); i++) c = crc_step(c, exp_q[i]);
        for (int i = 0; i < 4; i++) exp_q.push_back(~c[8*i +: 8]);
    endtask

    //************************************************************
    // drivers
    //************************************************************
    task automatic send_request(input int len, input logic [31:0] ip, input logic [47:0] mac);
        @(posedge clk);
        req_valid   <= 1'b1;
        req_len     <= 16'(len);
        req_des_ip  <= ip;
        req_des_mac <= mac;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
    endtask

    // with idle_chk set tx_en has to stay low while bytes are still coming
    task automatic push_bytes(input int n, input bit gaps, input bit idle_chk);
        int k;
        k = 0;
        while (k < n) begin
            @(posedge clk);
            if (pay_valid && pay_ready) k++;
            if (idle_chk) compare_values(gmii_tx_en, 0, "tx_en before payload complete");
            if (k < n && (!gaps || ($urandom % 3) != 0)) begin
                pay_data  <= pay_q[k];
                pay_valid <= 1'b1;
            end else begin
                pay_valid <= 1'b0;
            end
        end
    endtask

    task automatic wait_frame(input int base);
        int n;
        n = 0;
        while (done_cnt == base && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (done_cnt == base) begin
            $display("no frame: tx_done did not come within 2000 cycles");
            $display("TEST FAILED");
            $fatal(1, "missing frame");
        end
        repeat (3) @(negedge clk);
        compare_values(done_cnt - base, 1, "tx_done pulse count");
    endtask

    task automatic run_frame(input int len, input logic [31:0] ip, input logic [47:0] mac,
                             input bit req_first);
        int base;
        @(negedge clk);
        rx_q.delete();
        base = done_cnt;
        pay_q.delete();
        for (int i = 0; i < len; i++) pay_q.push_back(8'($urandom));
        if (req_first) begin
            send_request(len, ip, mac);
            push_bytes(len, 1'b1, 1'b1);
        end else begin
            push_bytes(len, 1'b0, 1'b0);
            send_request(len, ip, mac);
        end
        wait_frame(base);
        build_frame(len, ip, mac);
        next_ident = next_ident + 16'd1;
        compare_values(rx_q.size(), exp_q.size(), "frame length");
        for (int i = 0; i < exp_q.size(); i++) begin
            compare_values(rx_q[i], exp_q[i], $sformatf("frame byte %0d", i));
        end
    endtask

    //************************************************************
    // tests
    //************************************************************
    task automatic check_after_reset();
        @(posedge clk);
        compare_values(gmii_tx_en, 0, "tx_en after reset");
        compare_values(tx_done, 0, "tx_done after reset");
        compare_values(req_ready, 1, "req_ready after reset");
    endtask

    task automatic default_address_frames();
        logic [15:0] id_exp;
        id_exp = next_ident; // ident of the first of the two frames
        run_frame(20, '0, '0, 1'b0);
        compare_values({rx_q[26], rx_q[27]}, id_exp, "ident first frame");
        run_frame(24, '0, '0, 1'b0);
        compare_values({rx_q[26], rx_q[27]}, id_exp + 16'd1, "ident step");
    endtask

    task automatic backpressure_frames();
        run_frame(40, 32'h0a00_0005, 48'h0200_0000_0005, 1'b1);
        pay_q.delete();
        for (int i = 0; i < PAY_FIFO_DEPTH; i++) pay_q.push_back(8'(i ^ (i >> 3)));
        push_bytes(PAY_FIFO_DEPTH, 1'b0, 1'b0);
        @(posedge clk);
        compare_values(pay_ready, 0, "pay_ready with full buffer");
    endtask

    initial begin
        void'($urandom(47095));
        rst_n       = 1'b0;
        req_valid   = 1'b0;
        req_len     = '0;
        req_des_ip  = '0;
        req_des_mac = '0;
        pay_data    = '0;
        pay_valid   = 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        check_after_reset();
        run_frame(32, 32'hc0a8_0164, 48'h0011_2233_4455, 1'b0); // 8+14+28+32+4
        run_frame(5, 32'hc0a8_0165, 48'h0011_2233_4466, 1'b0);  // 13 pad bytes
        default_address_frames();
        backpressure_frames();
        $display("TEST OK");
        $finish;
    end

endmodule

// ==== verilog/eth_crc32.sv ====
`timescale 1ns/1ps

module eth_crc32 (
    input  logic clk,
    input  logic rst_n,
    crc_if.engine crc
);
    import udp_tx_pkg::*;

    logic [31:0] crc_q;
    logic [31:0] crc_next;

    // one byte through the reflected polynomial, lsb first
    function automatic logic [31:0] crc_byte(input logic [31:0] c_in,
                                             input logic [7:0]  d);
        logic [31:0] c;
        c = c_in ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    assign crc_next = crc_byte(crc_q, crc.data);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= CRC_INIT;
        end else if (crc.clr) begin
            crc_q <= CRC_INIT; // ready for the next frame
        end else if (crc.en) begin
            crc_q <= crc_next;
        end
    end

    assign crc.crc = crc_q;

endmodule

// ==== verilog/payload_fifo.sv ====
`timescale 1ns/1ps

module payload_fifo (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] pay_data,
    input  logic       pay_valid,
    output logic       pay_ready,
    pay_stream_if.src  rd
);
    import udp_tx_pkg::*;

    logic [7:0]             mem [PAY_FIFO_DEPTH];
    logic [PAY_LEVEL_W-2:0] wr_ptr;
    logic [PAY_LEVEL_W-2:0] rd_ptr;
    logic [PAY_LEVEL_W-1:0] level;
    logic [7:0]             rd_data;
    logic                   push;
    logic                   pop;

    assign pay_ready = (level != PAY_LEVEL_W'(PAY_FIFO_DEPTH)); // not full
    assign push      = pay_valid & pay_ready;
    assign pop       = rd.ready & rd.valid;

    assign rd.valid = (level != '0);
    assign rd.level = level;
    assign rd.data  = rd_data;

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    // storage and read register
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pay_data;
        end
        if (pop) begin
            rd_data <= mem[rd_ptr]; // shows up the cycle after the pop
        end
    end

endmodule

// ==== verilog/udp_frame_tx.sv ====
`timescale 1ns/1ps

module udp_frame_tx (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [15:0] req_len,
    input  logic [31:0] req_des_ip,
    input  logic [47:0] req_des_mac,
    pay_stream_if.snk   pay,
    crc_if.host         crc,
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd,
    output logic        tx_done
);
    import udp_tx_pkg::*;

    logic [8:0]       state;
    logic [8:0]       state_nxt;
    logic [15:0]      cnt;       // position inside the current state
    logic [15:0]      cnt_nxt;
    logic             accept;
    logic             tx_en_nxt;
    logic [7:0]       txd_nxt;
    logic             crc_feed;
    logic             rd_req;

    logic [15:0]      ip_ident;
    logic [15:0]      len_r;
    logic [47:0]      des_mac_r;
    ip_word_u         hdr [7];   // IPv4 header then UDP header
    logic [31:0]      csum;
    logic [31:0]      csum_all;
    logic [13:0][7:0] eth_bytes;

    assign req_ready = (state == ST_IDLE);
    assign accept    = req_valid & req_ready;
    assign eth_bytes = {des_mac_r, BOARD_MAC, ETH_TYPE_IPV4};

    // sum of the ten IPv4 halfwords
    always_comb begin
        csum_all = '0;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 2; j++) begin
                csum_all = csum_all + 32'(hdr[i].half[j]);
            end
        end
    end

    //**********************************************************
    // request capture and header checksum
    //**********************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ip_ident <= '0;
        end else if (accept) begin
            ip_ident <= ip_ident + 16'd1; // first frame carries 1
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            len_r     <= req_len;
            des_mac_r <= (req_des_mac != '0) ? req_des_mac : DEFAULT_DES_MAC;
            hdr[0]    <= {IP_VER_IHL, 8'h00, req_len + IP_UDP_HDR_BYTES};
            hdr[1]    <= {ip_ident + 16'd1, IP_FLAGS};
            hdr[2]    <= {IP_TTL, IP_PROTO_UDP, 16'h0000}; // checksum filled later
            hdr[3]    <= BOARD_IP;
            hdr[4]    <= (req_des_ip != '0) ? req_des_ip : DEFAULT_DES_IP;
            hdr[5]    <= {UDP_PORT, UDP_PORT};
            hdr[6]    <= {req_len + UDP_HDR_BYTES, 16'h0000}; // no udp checksum
        end else if (state == ST_CHECK) begin
            case (cnt[1:0])
                2'd0: csum <= csum_all;
                2'd1: csum <= 32'(csum[31:16]) + 32'(csum[15:0]); // fold carries
                2'd2: csum <= 32'(csum[31:16]) + 32'(csum[15:0]); // and once more
                default: hdr[2].half[0] <= ~csum[15:0];
            endcase
        end
    end

    //**********************************************************
    // frame sequencing
    //**********************************************************
    // the *_nxt values land on gmii one cycle later
    always_comb begin
        state_nxt = state;
        cnt_nxt   = cnt;
        tx_en_nxt = 1'b0;
        txd_nxt   = 8'd0;
        crc_feed  = 1'b0;
        rd_req    = 1'b0;
        case (state)
            ST_IDLE: begin
                if (req_valid) begin
                    state_nxt = ST_WAIT;
                    cnt_nxt   = '0;
                end
            end
            ST_WAIT: begin
                // whole payload buffered so the data phase never stalls
                if (16'(pay.level) >= len_r) begin
                    state_nxt = ST_CHECK;
                end
            end
            ST_CHECK: begin
                cnt_nxt = cnt + 16'd1;
                if (cnt == 16'd3) begin
                    state_nxt = ST_PREAMBLE;
                    cnt_nxt   = '0;
                end
            end
            ST_PREAMBLE: begin
                tx_en_nxt = 1'b1;
                txd_nxt   = (cnt == 16'd7) ? SFD_BYTE : PREAMBLE_BYTE;
                cnt_nxt   = cnt + 16'd1;
                if (cnt == 16'd7) begin
                    state_nxt = ST_ETH_HEAD;
                    cnt_nxt   = '0;
                end
            end
            ST_ETH_HEAD: begin
                tx_en_nxt = 1'b1;
                crc_feed  = 1'b1;
                txd_nxt   = eth_bytes[4'd13 - cnt[3:0]];
                cnt_nxt   = cnt + 16'd1;
                if (cnt == 16'd13) begin
                    state_nxt = ST_IP_HEAD;
                    cnt_nxt   = '0;
                end
            end
            ST_IP_HEAD: begin
                tx_en_nxt = 1'b1;
                crc_feed  = 1'b1;
                txd_nxt   = hdr[cnt[4:2]].bytes[2'd3 - cnt[1:0]];
                cnt_nxt   = cnt + 16'd1;
                if (cnt == 16'd27) begin
                    cnt_nxt = '0;
                    if (len_r == '0) begin
                        state_nxt = ST_PAD;
                    end else begin
                        rd_req    = 1'b1; // first byte one cycle early
                        state_nxt = ST_TX_DATA;
                    end
                end
            end
            ST_TX_DATA: begin
                tx_en_nxt = 1'b1;
                crc_feed  = 1'b1;
                txd_nxt   = pay.data;
                rd_req    = (cnt + 16'd1 < len_r);
                cnt_nxt   = cnt + 16'd1;
                if (cnt == len_r - 16'd1) begin
                    if (len_r < MIN_PAYLOAD) begin
                        state_nxt = ST_PAD; // cnt keeps counting
                    end else begin
                        state_nxt = ST_FCS;
                        cnt_nxt   = '0;
                    end
                end
            end
            ST_PAD: begin
                tx_en_nxt = 1'b1;
                crc_feed  = 1'b1;
                cnt_nxt   = cnt + 16'd1;
                if (cnt == MIN_PAYLOAD - 16'd1) begin
                    state_nxt = ST_FCS;
                    cnt_nxt   = '0;
                end
            end
            ST_FCS: begin
                tx_en_nxt = 1'b1;
                txd_nxt   = ~crc.crc[{cnt[1:0], 3'b000} +: 8]; // low byte first
                cnt_nxt   = cnt + 16'd1;
                if (cnt == 16'd3) begin
                    state_nxt = ST_IDLE;
                    cnt_nxt   = '0;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
                cnt_nxt   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            cnt        <= '0;
            gmii_tx_en <= 1'b0;
            gmii_txd   <= 8'd0;
            tx_done    <= 1'b0;
        end else begin
            state      <= state_nxt;
            cnt        <= cnt_nxt;
            gmii_tx_en <= tx_en_nxt;
            gmii_txd   <= txd_nxt;
            tx_done    <= gmii_tx_en & ~tx_en_nxt; // falling edge of tx_en
        end
    end

    // crc sees each byte at the edge it is registered onto gmii
    assign crc.data  = txd_nxt;
    assign crc.en    = crc_feed;
    assign crc.clr   = tx_done;
    assign pay.ready = rd_req;

endmodule

// ==== verilog/udp_tx_ifs.sv ====
`timescale 1ns/1ps

//**********************************************************
// payload stream from the buffer to the framer
//**********************************************************
interface pay_stream_if;
    import udp_tx_pkg::*;

    logic [7:0]             data;  // registered read data
    logic                   valid; // buffer not empty
    logic                   ready; // pop request
    logic [PAY_LEVEL_W-1:0] level; // bytes held

    modport src (
        output data,
        output valid,
        output level,
        input  ready
    );

    modport snk (
        input  data,
        input  valid,
        input  level,
        output ready
    );
endinterface

//**********************************************************
// byte feed into the CRC engine
//**********************************************************
interface crc_if;
    logic [7:0]  data;
    logic        en;
    logic        clr;
    logic [31:0] crc; // register value

    modport host (
        output data,
        output en,
        output clr,
        input  crc
    );

    modport engine (
        input  data,
        input  en,
        input  clr,
        output crc
    );
endinterface

// ==== verilog/udp_tx_pkg.sv ====
package udp_tx_pkg;

    //**********************************************************
    // addresses and ports
    //**********************************************************
    localparam logic [47:0] BOARD_MAC       = 48'ha0_b1_c2_d3_e1_e1;
    localparam logic [31:0] BOARD_IP        = 32'hc0_a8_01_0b; // 192.168.1.11
    localparam logic [47:0] DEFAULT_DES_MAC = 48'h84_a9_38_bf_c9_a0;
    localparam logic [31:0] DEFAULT_DES_IP  = 32'ha9_fe_33_78; // 169.254.51.120
    localparam logic [15:0] UDP_PORT        = 16'd1234;        // src and dst

    //**********************************************************
    // protocol constants
    //**********************************************************
    localparam logic [7:0]  PREAMBLE_BYTE     = 8'h55;
    localparam logic [7:0]  SFD_BYTE          = 8'hd5;
    localparam logic [15:0] ETH_TYPE_IPV4     = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL        = 8'h45;   // v4, 5 words
    localparam logic [15:0] IP_FLAGS          = 16'h4000; // don't fragment
    localparam logic [7:0]  IP_TTL            = 8'h40;
    localparam logic [7:0]  IP_PROTO_UDP      = 8'd17;
    localparam logic [15:0] IP_UDP_HDR_BYTES  = 16'd28;
    localparam logic [15:0] UDP_HDR_BYTES     = 16'd8;
    localparam logic [15:0] MIN_PAYLOAD       = 16'd18;   // 46 byte min minus headers
    localparam logic [31:0] CRC_POLY          = 32'hedb88320; // reflected
    localparam logic [31:0] CRC_INIT          = 32'hffff_ffff;

    // payload buffer
    localparam int PAY_FIFO_DEPTH = 256;
    localparam int PAY_LEVEL_W    = 9;

    // framer states, one-hot
    localparam logic [8:0] ST_IDLE     = 9'b0_0000_0001;
    localparam logic [8:0] ST_WAIT     = 9'b0_0000_0010;
    localparam logic [8:0] ST_CHECK    = 9'b0_0000_0100;
    localparam logic [8:0] ST_PREAMBLE = 9'b0_0000_1000;
    localparam logic [8:0] ST_ETH_HEAD = 9'b0_0001_0000;
    localparam logic [8:0] ST_IP_HEAD  = 9'b0_0010_0000;
    localparam logic [8:0] ST_TX_DATA  = 9'b0_0100_0000;
    localparam logic [8:0] ST_PAD      = 9'b0_1000_0000;
    localparam logic [8:0] ST_FCS      = 9'b1_0000_0000;

    // one IP/UDP header word
    // bytes[3] goes out first, half[1] is the upper halfword
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] half;
    } ip_word_u;

endpackage

// ==== verilog/udp_tx_top.sv ====
`timescale 1ns/1ps

module udp_tx_top (
    input  logic        clk,
    input  logic        rst_n,

    // frame request
    input  logic        req_valid,
    output logic        req_ready,
    input  logic [15:0] req_len,
    input  logic [31:0] req_des_ip,
    input  logic [47:0] req_des_mac,

    // payload bytes
    input  logic [7:0]  pay_data,
    input  logic        pay_valid,
    output logic        pay_ready,

    // GMII transmit
    output logic        gmii_tx_en,
    output logic [7:0]  gmii_txd,
    output logic        tx_done
);

    pay_stream_if pay_bus ();
    crc_if        crc_bus ();

    payload_fifo payload_fifo_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .pay_data  (pay_data),
        .pay_valid (pay_valid),
        .pay_ready (pay_ready),
        .rd        (pay_bus.src)
    );

    udp_frame_tx udp_frame_tx_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_ready   (req_ready),
        .req_len     (req_len),
        .req_des_ip  (req_des_ip),
        .req_des_mac (req_des_mac),
        .pay         (pay_bus.snk),
        .crc         (crc_bus.host),
        .gmii_tx_en  (gmii_tx_en),
        .gmii_txd    (gmii_txd),
        .tx_done     (tx_done)
    );

    eth_crc32 eth_crc32_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .crc   (crc_bus.engine)
    );

endmodule
